/* logic/conv_pe_pkg.sv */
package conv_pe_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////////////

    // ifmap and weight values, signed
    localparam int DATA_W  = 16;
    // psum and accumulator, signed, wraps modulo 2^32
    localparam int PSUM_W  = 32;
    // columns sharing the bus
    localparam int NUM_COL = 4;
    // weight buffer depth and largest kernel
    localparam int MAX_K   = 16;

    // derived widths
    localparam int TAG_W   = $clog2(NUM_COL);
    localparam int KSIZE_W = $clog2(MAX_K + 1);
    localparam int WIDX_W  = $clog2(MAX_K);

    ////////////////////////////////////////////////////////////////////////////
    // vector types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [PSUM_W-1:0]  psum_t;
    typedef logic [TAG_W-1:0]   tag_t;
    // legal range 1 to 16
    typedef logic [KSIZE_W-1:0] ksize_t;
    typedef logic [WIDX_W-1:0]  widx_t;

    // one bus beat as broadcast to the column
    typedef struct packed {
        tag_t  id;
        data_t ifmap;
        psum_t psum;
    } cast_beat_t;

    // operand handed to the mac pe
    typedef struct packed {
        data_t ifmap;
        data_t weight;
        psum_t psum;
        logic  first;
        logic  last;
    } pe_op_t;

    // weight buffer control
    typedef enum logic [1:0] {
        WB_IDLE,
        WB_LOAD,
        WB_READY
    } wbuf_state_t;

endpackage

/* logic/weight_buffer.sv */
`timescale 1ns/100ps

module weight_buffer (
    input  logic                clk,
    input  logic                rstn,
    input  logic                flush,
    input  conv_pe_pkg::ksize_t kernel_size,
    input  conv_pe_pkg::data_t  weight_data,
    input  logic                rd_en,
    output conv_pe_pkg::data_t  weight,
    output logic                flush_busy
);

    conv_pe_pkg::wbuf_state_t state;
    // kernel size seen at the last flush
    conv_pe_pkg::ksize_t      k_q;
    conv_pe_pkg::widx_t       load_cnt;
    conv_pe_pkg::widx_t       rd_ptr;
    // index of the final weight, K-1
    conv_pe_pkg::widx_t       last_idx;
    conv_pe_pkg::data_t       mem [conv_pe_pkg::MAX_K];

    assign last_idx = conv_pe_pkg::widx_t'(k_q - 5'd1);

    ////////////////////////////////////////////////////////////////////////////
    // load and read control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= conv_pe_pkg::WB_IDLE;
            k_q      <= conv_pe_pkg::ksize_t'(1);
            load_cnt <= '0;
            rd_ptr   <= '0;
        end else if (flush) begin
            // a flush always restarts the load, even mid-load
            state    <= conv_pe_pkg::WB_LOAD;
            k_q      <= kernel_size;
            load_cnt <= '0;
            rd_ptr   <= '0;
        end else begin
            case (state)
                conv_pe_pkg::WB_LOAD: begin
                    // K-th weight written on this edge
                    if (load_cnt == last_idx) begin
                        state <= conv_pe_pkg::WB_READY;
                    end
                    load_cnt <= load_cnt + 1'b1;
                end
                conv_pe_pkg::WB_READY: begin
                    // cyclic read, wraps after K-1
                    if (rd_en) begin
                        if (rd_ptr == last_idx) begin
                            rd_ptr <= '0;
                        end else begin
                            rd_ptr <= rd_ptr + 1'b1;
                        end
                    end
                end
                default: begin
                    // idle until the first flush
                    state <= conv_pe_pkg::WB_IDLE;
                end
            endcase
        end
    end

    // weight storage, one entry per load cycle
    always_ff @(posedge clk) begin
        if (state == conv_pe_pkg::WB_LOAD && !flush) begin
            mem[load_cnt] <= weight_data;
        end
    end

    // unconfigured slice multiplies by zero
    assign weight     = (state == conv_pe_pkg::WB_READY) ? mem[rd_ptr] : '0;
    assign flush_busy = (state == conv_pe_pkg::WB_LOAD);

endmodule

/* logic/multicaster.sv */
`timescale 1ns/100ps

module multicaster (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    flush,
    input  conv_pe_pkg::ksize_t     cfg_kernel_size,
    input  conv_pe_pkg::tag_t       cfg_tag,
    input  logic                    beat_valid,
    input  conv_pe_pkg::cast_beat_t beat,
    input  logic                    flush_busy,
    input  conv_pe_pkg::data_t      wb_weight,
    output logic                    wb_rd_en,
    output logic                    op_valid,
    output conv_pe_pkg::pe_op_t     op
);

    // configuration latched at flush
    conv_pe_pkg::tag_t   tag_q;
    conv_pe_pkg::ksize_t k_q;

    // beats already taken in the current window
    conv_pe_pkg::widx_t  win_cnt;
    conv_pe_pkg::widx_t  last_idx;

    logic                accept;
    logic                win_first;
    logic                win_last;

    ////////////////////////////////////////////////////////////////////////////
    // configuration
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tag_q <= '0;
            k_q   <= conv_pe_pkg::ksize_t'(1);
        end else if (flush) begin
            tag_q <= cfg_tag;
            k_q   <= cfg_kernel_size;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // beat filter and window markers
    ////////////////////////////////////////////////////////////////////////////

    // own column only, nothing while weights load
    assign accept = beat_valid && !flush && !flush_busy && (beat.id == tag_q);

    // buffer read pointer steps with every accepted beat
    assign wb_rd_en = accept;

    assign last_idx  = conv_pe_pkg::widx_t'(k_q - 5'd1);
    assign win_first = (win_cnt == '0);
    assign win_last  = (win_cnt == last_idx);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            win_cnt <= '0;
        end else if (flush) begin
            win_cnt <= '0;
        end else if (accept) begin
            // back to zero once the K-th beat is in
            if (win_last) begin
                win_cnt <= '0;
            end else begin
                win_cnt <= win_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // operand register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            op_valid <= 1'b0;
        end else begin
            op_valid <= accept;
        end
    end

    // pair the beat with the current buffer weight
    always_ff @(posedge clk) begin
        if (accept) begin
            op.ifmap  <= beat.ifmap;
            op.weight <= wb_weight;
            op.psum   <= beat.psum;
            op.first  <= win_first;
            op.last   <= win_last;
        end
    end

endmodule

/* logic/mac_pe.sv */
`timescale 1ns/100ps

module mac_pe (
    input  logic                clk,
    input  logic                rstn,
    input  logic                op_valid,
    input  conv_pe_pkg::pe_op_t op,
    output logic                psum_valid,
    output conv_pe_pkg::psum_t  psum_out
);

    // stage 1 registers
    logic               s1_valid;
    conv_pe_pkg::psum_t s1_prod;
    conv_pe_pkg::psum_t s1_psum;
    logic               s1_first;
    logic               s1_last;

    // stage 2 accumulator
    conv_pe_pkg::psum_t acc;
    conv_pe_pkg::psum_t acc_next;

    ////////////////////////////////////////////////////////////////////////////
    // stage 1, signed multiply
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= op_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid) begin
            // 16x16 signed product fills the 32-bit psum
            s1_prod  <= conv_pe_pkg::psum_t'($signed(op.ifmap) * $signed(op.weight));
            s1_psum  <= op.psum;
            s1_first <= op.first;
            s1_last  <= op.last;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage 2, accumulate
    ////////////////////////////////////////////////////////////////////////////

    // first beat seeds with the incoming psum
    assign acc_next = s1_first ? (s1_psum + s1_prod) : (acc + s1_prod);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            psum_valid <= 1'b0;
        end else begin
            psum_valid <= s1_valid && s1_last;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            acc <= acc_next;
            // result held until the next window closes
            if (s1_last) begin
                psum_out <= acc_next;
            end
        end
    end

endmodule

/* logic/pe_cast_top.sv */
`timescale 1ns/100ps

module pe_cast_top (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    flush,
    input  conv_pe_pkg::ksize_t     cfg_kernel_size,
    input  conv_pe_pkg::tag_t       cfg_tag,
    input  conv_pe_pkg::data_t      weight_data,
    input  logic                    beat_valid,
    input  conv_pe_pkg::cast_beat_t beat,
    output logic                    flush_busy,
    output logic                    psum_valid,
    output conv_pe_pkg::psum_t      psum_out
);

    // multicaster to buffer
    logic                wb_rd_en;
    conv_pe_pkg::data_t  wb_weight;
    // multicaster to pe
    logic                op_valid;
    conv_pe_pkg::pe_op_t op;

    multicaster i_multicaster (
        .clk             (clk),
        .rstn            (rstn),
        .flush           (flush),
        .cfg_kernel_size (cfg_kernel_size),
        .cfg_tag         (cfg_tag),
        .beat_valid      (beat_valid),
        .beat            (beat),
        .flush_busy      (flush_busy),
        .wb_weight       (wb_weight),
        .wb_rd_en        (wb_rd_en),
        .op_valid        (op_valid),
        .op              (op)
    );

    // weights come straight from the bus during the load
    weight_buffer i_weight_buffer (
        .clk         (clk),
        .rstn        (rstn),
        .flush       (flush),
        .kernel_size (cfg_kernel_size),
        .weight_data (weight_data),
        .rd_en       (wb_rd_en),
        .weight      (wb_weight),
        .flush_busy  (flush_busy)
    );

    mac_pe i_mac_pe (
        .clk        (clk),
        .rstn       (rstn),
        .op_valid   (op_valid),
        .op         (op),
        .psum_valid (psum_valid),
        .psum_out   (psum_out)
    );

endmodule

/* verification/pe_cast_checker.sv */
`timescale 1ns/100ps

module pe_cast_checker (
    input  logic                clk,
    input  logic                rstn,
    input  logic                flush,
    input  conv_pe_pkg::ksize_t cfg_kernel_size,
    input  logic                flush_busy,
    input  logic                psum_valid,
    input  conv_pe_pkg::psum_t  psum_out,
    input  logic                exp_push,
    input  conv_pe_pkg::psum_t  exp_psum,
    input  int                  exp_edge,
    output int                  edge_cnt,
    output int                  pending,
    output int                  psum_errs,
    output int                  busy_errs,
    output int                  seq_errs
);

    // expected window result and the edge it is due on
    typedef struct packed {
        conv_pe_pkg::psum_t psum;
        logic [31:0]        due;
    } exp_item_t;

    exp_item_t exp_q[$];
    // load cycles still ahead since the last flush
    int        busy_left;

    // edge counter and flush_busy model, sampled like the DUT
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            edge_cnt  <= 0;
            busy_left <= 0;
        end else begin
            edge_cnt <= edge_cnt + 1;
            if (flush) begin
                // a flush mid-load starts the count again
                busy_left <= int'(cfg_kernel_size);
            end else if (busy_left > 0) begin
                busy_left <= busy_left - 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // compare on the falling edge, outputs settled
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        exp_item_t item;
        if (!rstn) begin
            psum_errs = 0;
            busy_errs = 0;
            seq_errs  = 0;
            exp_q.delete();
        end else begin
            if (exp_push) begin
                exp_q.push_back('{psum: exp_psum, due: exp_edge});
            end
            if (flush_busy !== (busy_left != 0)) begin
                busy_errs++;
                $display("Fail flush_busy: got %h, expected %h at edge %0d",
                         flush_busy, busy_left != 0, edge_cnt);
            end
            if (psum_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    seq_errs++;
                    $display("psum_valid pulsed at edge %0d with no result expected", edge_cnt);
                end else begin
                    item = exp_q.pop_front();
                    if (int'(item.due) != edge_cnt) begin
                        seq_errs++;
                        $display("result came out at edge %0d but was due at edge %0d",
                                 edge_cnt, item.due);
                    end
                    if (psum_out !== item.psum) begin
                        psum_errs++;
                        $display("Fail psum_out: got %h, expected %h", psum_out, item.psum);
                    end
                end
            end else if (exp_q.size() != 0 && int'(exp_q[0].due) < edge_cnt) begin
                // due edge passed with no pulse
                item = exp_q.pop_front();
                seq_errs++;
                $display("psum_valid missing, result was due at edge %0d", item.due);
            end
        end
        pending = exp_q.size();
    end

endmodule

/* verification/pe_cast_tb.sv */
`timescale 1ns/100ps

module pe_cast_tb;

    logic                    clk;
    logic                    rstn;
    logic                    flush;
    conv_pe_pkg::ksize_t     cfg_kernel_size;
    conv_pe_pkg::tag_t       cfg_tag;
    conv_pe_pkg::data_t      weight_data;
    logic                    beat_valid;
    conv_pe_pkg::cast_beat_t beat;
    logic                    flush_busy;
    logic                    psum_valid;
    conv_pe_pkg::psum_t      psum_out;

    // expected results handed to the checker
    logic                    exp_push;
    conv_pe_pkg::psum_t      exp_psum;
    int                      exp_edge;
    int                      edge_cnt;
    int                      pending;
    int                      psum_errs;
    int                      busy_errs;
    int                      seq_errs;
    int                      timeouts;

    // slice model, configuration plus the open window
    logic [31:0]             lfsr;
    logic                    configured;
    conv_pe_pkg::tag_t       m_tag;
    int                      m_k;
    int                      m_ptr;
    int                      m_cnt;
    conv_pe_pkg::data_t      m_w   [conv_pe_pkg::MAX_K];
    conv_pe_pkg::data_t      win_x [conv_pe_pkg::MAX_K];
    conv_pe_pkg::data_t      win_w [conv_pe_pkg::MAX_K];
    conv_pe_pkg::psum_t      win_psum;

    pe_cast_top i_dut (.*);

    pe_cast_checker i_checker (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // a quarter of the values land on the signed extremes
    function automatic conv_pe_pkg::data_t rand_data();
        logic [2:0] sel;
        sel = 3'(rand_bits(3));
        if (sel == 3'd0) begin
            return 16'h8000;
        end else if (sel == 3'd1) begin
            return 16'h7fff;
        end
        return 16'(rand_bits(16));
    endfunction

    // first psum plus sum of ifmap times weight, mod 2^32
    function automatic conv_pe_pkg::psum_t ref_window(input conv_pe_pkg::psum_t seed,
                                                      input int k);
        longint acc;
        acc = longint'($signed(seed));
        for (int i = 0; i < k; i++) begin
            acc += longint'($signed(win_x[i])) * longint'($signed(win_w[i]));
        end
        return conv_pe_pkg::psum_t'(acc);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            flush      <= 1'b0;
            beat_valid <= 1'b0;
            exp_push   <= 1'b0;
        end
    endtask

    // one bus beat, the model decides if the slice takes it
    task automatic send_beat(input conv_pe_pkg::tag_t id, input conv_pe_pkg::data_t x,
                             input conv_pe_pkg::psum_t ps);
        @(posedge clk);
        flush      <= 1'b0;
        beat_valid <= 1'b1;
        beat       <= '{id: id, ifmap: x, psum: ps};
        exp_push   <= 1'b0;
        if (id == m_tag) begin
            win_x[m_cnt] = x;
            // unconfigured slice multiplies by zero, pointer stays
            win_w[m_cnt] = configured ? m_w[m_ptr] : '0;
            if (m_cnt == 0) begin
                win_psum = ps;
            end
            if (configured) begin
                m_ptr = (m_ptr + 1) % m_k;
            end
            m_cnt++;
            if (m_cnt == m_k) begin
                // taken at the next edge, result 2 edges after that
                exp_push <= 1'b1;
                exp_psum <= ref_window(win_psum, m_k);
                exp_edge <= edge_cnt + 4;
                m_cnt = 0;
            end
        end
    endtask

    // flush, then n_load load cycles with junk beats for the new tag
    task automatic do_flush(input int k, input conv_pe_pkg::tag_t tag, input int n_load);
        @(posedge clk);
        flush           <= 1'b1;
        cfg_kernel_size <= conv_pe_pkg::ksize_t'(k);
        cfg_tag         <= tag;
        beat_valid      <= 1'b1;
        beat            <= '{id: tag, ifmap: rand_data(), psum: '0};
        exp_push        <= 1'b0;
        configured = 1'b1;
        m_tag      = tag;
        m_k        = k;
        m_ptr      = 0;
        m_cnt      = 0;
        for (int i = 0; i < n_load; i++) begin
            m_w[i] = rand_data();
            @(posedge clk);
            flush       <= 1'b0;
            weight_data <= m_w[i];
            beat_valid  <= 1'(rand_bits(1));
            beat        <= '{id: tag, ifmap: rand_data(), psum: 32'(rand_bits(32))};
        end
    endtask

    // one full window, wrong-id beats and gaps mixed in
    task automatic run_window(input int gap_max);
        for (int i = 0; i < m_k; i++) begin
            if (rand_bits(2) == 0) begin
                // xor with 1 or 2 never gives the own tag
                send_beat(m_tag ^ 2'(1 + rand_bits(1)), rand_data(), 32'(rand_bits(32)));
            end
            send_beat(m_tag, rand_data(), 32'(rand_bits(32)));
            if (gap_max > 0) begin
                idle(int'(rand_bits(2)) % (gap_max + 1));
            end
        end
    endtask

    initial begin
        lfsr            = 32'ha000a5fa;
        rstn            = 1'b0;
        flush           = 1'b0;
        cfg_kernel_size = conv_pe_pkg::ksize_t'(1);
        cfg_tag         = '0;
        weight_data     = '0;
        beat_valid      = 1'b0;
        beat            = '0;
        exp_push        = 1'b0;
        exp_psum        = '0;
        exp_edge        = 0;
        configured      = 1'b0;
        m_tag           = '0;
        m_k             = 1;
        m_ptr           = 0;
        m_cnt           = 0;
        timeouts        = 0;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        idle(2);

        // before any flush, tag 0 with K of 1
        repeat (3) run_window(2);
        // smallest and largest K, back-to-back windows reuse weights
        do_flush(1, 2'd1, 1);
        repeat (3) run_window(1);
        do_flush(16, 2'd2, 16);
        repeat (3) run_window(0);
        // half a window, then a restarted load and a new tag
        repeat (5) send_beat(2'd2, rand_data(), 32'(rand_bits(32)));
        do_flush(9, 2'd3, 4);
        do_flush(7, 2'd3, 7);
        send_beat(2'd2, rand_data(), 32'(rand_bits(32)));
        repeat (2) run_window(2);
        // random configurations
        for (int c = 0; c < 8; c++) begin
            do_flush(1 + int'(rand_bits(4)), 2'(rand_bits(2)), 0);
            for (int i = 0; i < m_k; i++) begin
                m_w[i] = rand_data();
                @(posedge clk);
                flush       <= 1'b0;
                beat_valid  <= 1'b0;
                weight_data <= m_w[i];
            end
            repeat (3) run_window(3);
        end

        idle(4);
        // drain, bounded
        for (int t = 0; t < 20 && pending != 0; t++) begin
            @(posedge clk);
        end
        if (pending != 0) begin
            timeouts++;
            $display("timeout, %0d results never came out of the DUT", pending);
        end
        idle(4);

        $display("errors: psum_out %0d, flush_busy %0d, psum_valid %0d, timeout %0d",
                 psum_errs, busy_errs, seq_errs, timeouts);
        if (psum_errs + busy_errs + seq_errs + timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* pe_cast_top.f */
logic/conv_pe_pkg.sv
logic/weight_buffer.sv
logic/multicaster.sv
logic/mac_pe.sv
logic/pe_cast_top.sv
verification/pe_cast_checker.sv
verification/pe_cast_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the pe_cast testbench with verilator, run it, and grep the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module pe_cast_tb \
    -f pe_cast_top.f -o pe_cast_sim \
    && ./obj_dir/pe_cast_sim > sim.log 2>&1 \
    || { echo "build or simulation run failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "^TEST OK$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
